/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= sys_id_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
source/sys_bus_pkg.sv
source/id_pkg.sv
source/bus_decode.sv
source/dna_reader.sv
source/dna_port_model.sv
source/id_regs.sv
source/bus_result.sv
source/sys_id_top.sv
tb/sys_id_assert.sv
tb/sys_id_tb.sv

/* source/bus_decode.sv */
/* Decode stage of the bus pipeline.
   Registers each request with its region and register select. */
module bus_decode (
  input  logic                 bus,
  input  logic                 rst_n,
  input  sys_bus_pkg::bus_req_t req,
  output id_pkg::decoded_req_t dec
);

  id_pkg::region_t  region_c;
  id_pkg::reg_sel_t sel_c;

  // Upper address bits pick the region
  assign region_c = (req.addr[sys_bus_pkg::BUS_AW-1:id_pkg::ID_DECODE_W] == '0) ?
                    id_pkg::REGION_ID : id_pkg::REGION_NONE;

  // Low bits pick the register
  always_comb begin
    case (req.addr[id_pkg::ID_DECODE_W-1:0])
      id_pkg::OFS_ID:     sel_c = id_pkg::REG_ID;
      id_pkg::OFS_DNA_LO: sel_c = id_pkg::REG_DNA_LO;
      id_pkg::OFS_DNA_HI: sel_c = id_pkg::REG_DNA_HI;
      id_pkg::OFS_GITH0:  sel_c = id_pkg::REG_GITH0;
      id_pkg::OFS_GITH1:  sel_c = id_pkg::REG_GITH1;
      id_pkg::OFS_GITH2:  sel_c = id_pkg::REG_GITH2;
      id_pkg::OFS_GITH3:  sel_c = id_pkg::REG_GITH3;
      id_pkg::OFS_GITH4:  sel_c = id_pkg::REG_GITH4;
      // Holes in the map
      default:            sel_c = id_pkg::REG_NONE;
    endcase
  end

  // Stage register
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      dec <= '0;
    end else begin
      dec.valid   <= req.wen | req.ren;
      // A write strobe wins over a read strobe
      dec.write   <= req.wen;
      dec.region  <= region_c;
      dec.reg_sel <= sel_c;
    end
  end

endmodule

/* source/bus_result.sv */
/* Result stage of the bus pipeline.
   Registers ack, read data and the error flag onto the bus response. */
module bus_result (
  input  logic                           bus,
  input  logic                           rst_n,
  input  id_pkg::decoded_req_t           dec,
  input  logic                           ex_valid,
  input  logic [sys_bus_pkg::BUS_DW-1:0] ex_data,
  output sys_bus_pkg::bus_rsp_t          rsp
);

  // Region of the request now in execute
  id_pkg::region_t                region_q;
  logic                           ack_q;
  logic                           err_q;
  logic [sys_bus_pkg::BUS_DW-1:0] rdata_q;

  // Region follows the request into execute
  always_ff @(posedge bus) begin
    region_q <= dec.region;
  end

  // Control, err high throughout reset
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b1;
    end else begin
      ack_q <= ex_valid;
      // Unmapped region flags an error on its ack
      err_q <= ex_valid && (region_q == id_pkg::REGION_NONE);
    end
  end

  // Read data
  always_ff @(posedge bus) begin
    rdata_q <= ex_data;
  end

  assign rsp.rdata = rdata_q;
  assign rsp.ack   = ack_q;
  assign rsp.err   = err_q;

endmodule

/* source/dna_port_model.sv */
/* Behavioral stand-in for the vendor DNA port primitive.
   Loads its DNA value on read and shifts it out MSB first on shift. */
module dna_port_model #(
  parameter logic [id_pkg::DNA_W-1:0] SIM_DNA_VALUE = 57'h0823456789abcde
) (
  input  logic clk,
  input  logic read,
  input  logic shift,
  output logic dout
);

  ////////////////////
  // Shift register
  ////////////////////

  logic [id_pkg::DNA_W-1:0] dna_sr;

  // Read has priority over shift, as in the primitive
  always_ff @(posedge clk) begin
    if (read) begin
      dna_sr <= SIM_DNA_VALUE;
    end else if (shift) begin
      // Zero fills from the serial input side
      dna_sr <= {dna_sr[id_pkg::DNA_W-2:0], 1'b0};
    end
  end

  ////////////////////
  // Serial output
  ////////////////////

  // Current MSB, valid right after load
  assign dout = dna_sr[id_pkg::DNA_W-1];

endmodule

/* source/dna_reader.sv */
/* Startup sequencer for the device DNA port.
   Loads the DNA, then shifts it out MSB first and flags completion. */
module dna_reader (
  input  logic                     bus,
  input  logic                     rst_n,
  input  logic                     dna_dout,
  output logic                     dna_clk,
  output logic                     dna_read,
  output logic                     dna_shift,
  output logic [id_pkg::DNA_W-1:0] dna_value,
  output logic                     dna_done
);

  id_pkg::dna_state_t               state;
  // DNA clock divider
  logic [id_pkg::DNA_DIV_LOG2-1:0]  div_cnt;
  // Load cycles, then captured bits
  logic [$clog2(id_pkg::DNA_W)-1:0] step_cnt;

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      state     <= id_pkg::DNA_LOAD;
      div_cnt   <= '0;
      step_cnt  <= '0;
      dna_clk   <= 1'b0;
      dna_read  <= 1'b0;
      dna_shift <= 1'b0;
      dna_value <= '0;
      dna_done  <= 1'b0;
    end else begin
      case (state)
        id_pkg::DNA_LOAD: begin
          // Load pulse spans one DNA clock rise
          div_cnt  <= div_cnt + 1'b1;
          dna_clk  <= div_cnt[id_pkg::DNA_DIV_LOG2-1];
          dna_read <= 1'b1;
          step_cnt <= step_cnt + 1'b1;
          if (32'(step_cnt) == id_pkg::DNA_READ_CYCLES - 1) begin
            state    <= id_pkg::DNA_SHIFT;
            // Restart divider so the MSB is sampled before the first shift
            div_cnt  <= '0;
            step_cnt <= '0;
          end
        end
        id_pkg::DNA_SHIFT: begin
          div_cnt   <= div_cnt + 1'b1;
          dna_clk   <= div_cnt[id_pkg::DNA_DIV_LOG2-1];
          dna_read  <= 1'b0;
          dna_shift <= 1'b1;
          // Sample while dout is stable, half a period after the rise
          if (div_cnt == '0) begin
            dna_value <= {dna_value[id_pkg::DNA_W-2:0], dna_dout};
            step_cnt  <= step_cnt + 1'b1;
            if (32'(step_cnt) == id_pkg::DNA_W - 1) begin
              state     <= id_pkg::DNA_DONE;
              dna_clk   <= 1'b0;
              dna_shift <= 1'b0;
              dna_done  <= 1'b1;
            end
          end
        end
        // Readout finished, port idle
        default: dna_clk <= 1'b0;
      endcase
    end
  end

endmodule

/* source/id_pkg.sv */
/* Constants and types of the system identification block.
   Covers DNA readout timing, the register map and the decoded request. */
package id_pkg;

  // DNA readout timing
  localparam int unsigned DNA_W           = 57;
  localparam int unsigned DNA_DIV_LOG2    = 3;
  localparam int unsigned DNA_READ_CYCLES = 10;

  // Register map inside the ID region
  localparam int unsigned ID_DECODE_W = 6;
  localparam logic [ID_DECODE_W-1:0] OFS_ID     = 6'h00;
  localparam logic [ID_DECODE_W-1:0] OFS_DNA_LO = 6'h08;
  localparam logic [ID_DECODE_W-1:0] OFS_DNA_HI = 6'h0c;
  localparam logic [ID_DECODE_W-1:0] OFS_GITH0  = 6'h10;
  localparam logic [ID_DECODE_W-1:0] OFS_GITH1  = 6'h14;
  localparam logic [ID_DECODE_W-1:0] OFS_GITH2  = 6'h18;
  localparam logic [ID_DECODE_W-1:0] OFS_GITH3  = 6'h1c;
  localparam logic [ID_DECODE_W-1:0] OFS_GITH4  = 6'h2c;

  // Address region
  typedef enum logic [0:0] {
    REGION_NONE = 1'b0,
    REGION_ID   = 1'b1
  } region_t;

  // Register select
  typedef enum logic [3:0] {
    REG_ID, REG_DNA_LO, REG_DNA_HI,
    REG_GITH0, REG_GITH1, REG_GITH2, REG_GITH3, REG_GITH4,
    REG_NONE
  } reg_sel_t;

  // DNA sequencer
  typedef enum logic [1:0] {DNA_LOAD, DNA_SHIFT, DNA_DONE} dna_state_t;

  // Output of the decode stage
  typedef struct packed {
    logic     valid;
    logic     write;
    region_t  region;
    reg_sel_t reg_sel;
  } decoded_req_t;

endpackage

/* source/id_regs.sv */
/* Execute stage of the bus pipeline.
   Maps the decoded register select to its read data word. */
module id_regs #(
  parameter logic [sys_bus_pkg::BUS_DW-1:0]   ID   = 32'h0000_0001,
  parameter logic [5*sys_bus_pkg::BUS_DW-1:0] GITH = '0
) (
  input  logic                            bus,
  input  logic                            rst_n,
  input  id_pkg::decoded_req_t            dec,
  input  logic [id_pkg::DNA_W-1:0]        dna_value,
  input  logic                            dna_done,
  output logic [sys_bus_pkg::BUS_DW-1:0]  ex_data,
  output logic                            ex_valid
);

  logic [sys_bus_pkg::BUS_DW-1:0] word;

  ////////////////////
  // Register mux
  ////////////////////

  always_comb begin
    word = '0;
    // Only reads in the ID region return data
    if (dec.valid && !dec.write && dec.region == id_pkg::REGION_ID) begin
      case (dec.reg_sel)
        id_pkg::REG_ID:     word = ID;
        id_pkg::REG_DNA_LO: word = dna_value[sys_bus_pkg::BUS_DW-1:0];
        // Busy flag on top, upper DNA bits at the bottom
        id_pkg::REG_DNA_HI: word = {~dna_done,
                                    {(2*sys_bus_pkg::BUS_DW-id_pkg::DNA_W-1){1'b0}},
                                    dna_value[id_pkg::DNA_W-1:sys_bus_pkg::BUS_DW]};
        // GITH0 is the least significant word
        id_pkg::REG_GITH0:  word = GITH[0*sys_bus_pkg::BUS_DW +: sys_bus_pkg::BUS_DW];
        id_pkg::REG_GITH1:  word = GITH[1*sys_bus_pkg::BUS_DW +: sys_bus_pkg::BUS_DW];
        id_pkg::REG_GITH2:  word = GITH[2*sys_bus_pkg::BUS_DW +: sys_bus_pkg::BUS_DW];
        id_pkg::REG_GITH3:  word = GITH[3*sys_bus_pkg::BUS_DW +: sys_bus_pkg::BUS_DW];
        id_pkg::REG_GITH4:  word = GITH[4*sys_bus_pkg::BUS_DW +: sys_bus_pkg::BUS_DW];
        default:            word = '0;
      endcase
    end
  end

  ////////////////////
  // Stage register
  ////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec.valid;
    end
  end

  // Data word
  always_ff @(posedge bus) begin
    ex_data <= word;
  end

endmodule

/* source/sys_bus_pkg.sv */
/* Types and widths of the memory-mapped system bus.
   Shared by the bus-facing stages and by the top level. */
package sys_bus_pkg;

  // Bus widths
  localparam int unsigned BUS_AW = 32;
  localparam int unsigned BUS_DW = 32;

  // Master request
  // A transfer is any cycle with wen or ren high
  typedef struct packed {
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
    logic              wen;
    logic              ren;
  } bus_req_t;

  // Slave response
  // One ack pulse per transfer, err qualifies the ack
  typedef struct packed {
    logic [BUS_DW-1:0] rdata;
    logic              ack;
    logic              err;
  } bus_rsp_t;

endpackage

/* source/sys_id_top.sv */
/* System identification block on the system bus.
   Three-stage register pipeline plus the startup DNA readout. */
module sys_id_top #(
  parameter logic [sys_bus_pkg::BUS_DW-1:0]   ID      = 32'h0000_0001,
  parameter logic [5*sys_bus_pkg::BUS_DW-1:0] GITH    = '0,
  parameter logic [id_pkg::DNA_W-1:0]         DNA_SIM = 57'h0823456789abcde
) (
  input  logic                  bus,
  input  logic                  rst_n,
  input  sys_bus_pkg::bus_req_t req,
  output sys_bus_pkg::bus_rsp_t rsp
);

  // Pipeline
  id_pkg::decoded_req_t           dec;
  logic [sys_bus_pkg::BUS_DW-1:0] ex_data;
  logic                           ex_valid;

  // DNA port
  logic                           dna_clk;
  logic                           dna_read;
  logic                           dna_shift;
  logic                           dna_dout;
  logic [id_pkg::DNA_W-1:0]       dna_value;
  logic                           dna_done;

  ////////////////////
  // Bus pipeline
  ////////////////////

  bus_decode u_bus_decode (.bus(bus), .rst_n(rst_n), .req(req), .dec(dec));

  id_regs #(.ID(ID), .GITH(GITH)) u_id_regs (
    .bus(bus), .rst_n(rst_n), .dec(dec), .dna_value(dna_value),
    .dna_done(dna_done), .ex_data(ex_data), .ex_valid(ex_valid)
  );

  bus_result u_bus_result (
    .bus(bus), .rst_n(rst_n), .dec(dec), .ex_valid(ex_valid),
    .ex_data(ex_data), .rsp(rsp)
  );

  ////////////////////
  // DNA readout
  ////////////////////

  dna_reader u_dna_reader (
    .bus(bus), .rst_n(rst_n), .dna_dout(dna_dout), .dna_clk(dna_clk),
    .dna_read(dna_read), .dna_shift(dna_shift), .dna_value(dna_value),
    .dna_done(dna_done)
  );

  dna_port_model #(.SIM_DNA_VALUE(DNA_SIM)) u_dna_port_model (
    .clk(dna_clk), .read(dna_read), .shift(dna_shift), .dout(dna_dout)
  );

endmodule

/* tb/sys_id_assert.sv */
/* Concurrent checks on the bus response timing of the identification block.
   Bound into sys_id_top, failures raise $error. */
module sys_id_assert (
  input logic                  bus,
  input logic                  rst_n,
  input sys_bus_pkg::bus_req_t req,
  input sys_bus_pkg::bus_rsp_t rsp
);

  logic [1:0] warm = 2'd0;
  logic       primed;
  logic       strobe;
  logic       in_id;
  int         ack_fails = 0;
  int         rst_fails = 0;
  int         err_fails = 0;

  // History depth for the three-cycle checks
  always @(posedge bus) begin
    if (warm != 2'd3) warm <= warm + 2'd1;
  end

  assign primed = (warm == 2'd3);
  assign strobe = req.wen | req.ren;
  assign in_id  = (req.addr[sys_bus_pkg::BUS_AW-1:id_pkg::ID_DECODE_W] == '0);

  // One ack per strobe, three edges later
  assert property (@(posedge bus)
    (primed && $past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3))
      |-> (rsp.ack == $past(strobe, 3)))
    else begin
      $error("ack not exactly three cycles after a strobe");
      ack_fails++;
    end

  // Error flag held through reset
  assert property (@(posedge bus) (primed && !$past(rst_n)) |-> rsp.err)
    else begin
      $error("err low while reset was asserted");
      rst_fails++;
    end

  // Requests inside the ID region never fail
  assert property (@(posedge bus) (primed && rsp.ack && $past(in_id, 3)) |-> !rsp.err)
    else begin
      $error("err high on an ack for an ID region address");
      err_fails++;
    end

endmodule

bind sys_id_top sys_id_assert u_sys_id_assert (
  .bus(bus), .rst_n(rst_n), .req(req), .rsp(rsp)
);

/* tb/sys_id_tb.sv */
/* Testbench for the system identification block on the system bus.
   Directed and random bus traffic checked against a reference register map. */
module sys_id_tb;

  localparam int DRIVE_DLY = 10;
  localparam int N_RANDOM  = 200;
  localparam int DNA_CYCLES = id_pkg::DNA_READ_CYCLES
                              + id_pkg::DNA_W * (2 ** id_pkg::DNA_DIV_LOG2);
  // Reset, readout, five cycles per request, then margin
  localparam int WATCHDOG_CYCLES = 10 + DNA_CYCLES + (N_RANDOM + 60) * 5 + 200;

  // Parameter words given to the DUT
  localparam logic [31:0]  ID_VAL   = 32'h5a1d_0c03;
  localparam logic [159:0] GITH_VAL = 160'h3e9f1c24_d07a58b6_91c3e2f0_6b4d8a17_c52e09f3;
  localparam logic [56:0]  DNA_VAL  = 57'h1_a5c3_9e07_b4d2_61;
  localparam logic [5:0]   MAP_OFS [8] = '{6'h00, 6'h08, 6'h0c, 6'h10,
                                           6'h14, 6'h18, 6'h1c, 6'h2c};

  // One issued request, oldest first in the queue
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic        poll;
  } pend_t;

  logic                  bus = 1'b0;
  logic                  rst_n;
  logic                  rst_seen = 1'b0;
  sys_bus_pkg::bus_req_t req;
  sys_bus_pkg::bus_rsp_t rsp;
  pend_t                 pend_q[$];
  string                 name_q[$];
  logic                  dna_ready = 1'b0;
  logic                  last_busy = 1'b1;
  int                    busy_polls = 0;
  int                    data_errs = 0;
  int                    proto_errs = 0;
  int                    assert_errs = 0;

  sys_id_top #(.ID(ID_VAL), .GITH(GITH_VAL), .DNA_SIM(DNA_VAL)) u_sys_id_top (
    .bus(bus), .rst_n(rst_n), .req(req), .rsp(rsp)
  );

  always #50 bus = ~bus;

  // Reset as the DUT saw it at the last edge
  always @(posedge bus) begin
    rst_seen <= rst_n;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic sys_bus_pkg::bus_rsp_t expect_rsp(
    input logic [31:0] addr, input logic write, input logic busy,
    input logic [31:0] id, input logic [159:0] gith, input logic [56:0] dna);
    sys_bus_pkg::bus_rsp_t r;
    r.rdata = '0;
    r.ack   = 1'b1;
    r.err   = 1'b0;
    if (addr[31:6] != '0) begin
      r.err = 1'b1;
    end else if (!write) begin
      case (addr[5:0])
        6'h00:   r.rdata = id;
        6'h08:   r.rdata = dna[31:0];
        6'h0c:   r.rdata = {busy, 6'd0, dna[56:32]};
        6'h10:   r.rdata = gith[31:0];
        6'h14:   r.rdata = gith[63:32];
        6'h18:   r.rdata = gith[95:64];
        6'h1c:   r.rdata = gith[127:96];
        6'h2c:   r.rdata = gith[159:128];
        default: r.rdata = '0;
      endcase
    end
    return r;
  endfunction

  ////////////////////
  // Response check
  ////////////////////

  // Mid-cycle sampling, response is stable here
  always @(negedge bus) begin : compare
    pend_t                 p;
    string                 nm;
    sys_bus_pkg::bus_rsp_t exp;
    if (!rst_seen) begin
      assert (!rsp.ack && rsp.err) else begin
        $display("Response during reset not idle: ack %b err %b", rsp.ack, rsp.err);
        proto_errs++;
      end
    end else if (rsp.ack) begin
      assert (pend_q.size() != 0) else begin
        $display("Unexpected acknowledge with no request outstanding at %0t", $time);
        proto_errs++;
      end
      if (pend_q.size() != 0) begin
        p   = pend_q.pop_front();
        nm  = name_q.pop_front();
        exp = expect_rsp(p.addr, p.write, !dna_ready, ID_VAL, GITH_VAL, DNA_VAL);
        // Poll reads see partial DNA bits, so only flag and gap are known
        if (p.poll) begin
          assert (rsp.err == 1'b0 && rsp.rdata[30:25] == 6'd0) else begin
            $display("ERROR %s: expected err 0 gap 00, actual err %b gap %h",
                     nm, rsp.err, rsp.rdata[30:25]);
            data_errs++;
          end
          last_busy = rsp.rdata[31];
          if (rsp.rdata[31]) busy_polls++;
        end else begin
          assert (rsp.rdata == exp.rdata) else begin
            $display("ERROR %s: addr %h expected rdata %h, actual %h",
                     nm, p.addr, exp.rdata, rsp.rdata);
            data_errs++;
          end
          assert (rsp.err == exp.err) else begin
            $display("ERROR %s: addr %h expected err %b, actual %b",
                     nm, p.addr, exp.err, rsp.err);
            data_errs++;
          end
        end
      end
    end else begin
      assert (!rsp.err) else begin
        $display("Error flag high without an acknowledge at %0t", $time);
        proto_errs++;
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Drive one request for one cycle
  task automatic send(input logic [31:0] addr, input logic write, input logic poll,
                      input string name);
    pend_t p;
    p = '{addr: addr, write: write, poll: poll};
    req.addr  = addr;
    req.wdata = $urandom;
    req.wen   = write;
    req.ren   = !write;
    pend_q.push_back(p);
    name_q.push_back(name);
    @(posedge bus);
    #DRIVE_DLY;
  endtask

  // Bus idle until every request is answered
  task automatic drain();
    req.wen = 1'b0;
    req.ren = 1'b0;
    while (pend_q.size() != 0) begin
      @(posedge bus);
    end
    @(posedge bus);
    #DRIVE_DLY;
  endtask

  initial begin : stimulus
    logic [31:0] r;
    logic [2:0]  idx;
    int          k;
    int          sel;
    void'($urandom(32'h7d03));
    rst_n = 1'b0;
    req   = '0;
    repeat (10) @(posedge bus);
    #DRIVE_DLY;
    rst_n = 1'b1;
    // Quiet bus, no ack expected
    repeat (20) @(posedge bus);
    #DRIVE_DLY;
    // Whole ID region except the DNA words
    for (k = 0; k < 16; k++) begin
      if (k != 2 && k != 3) send({26'd0, 4'(k), 2'b00}, 1'b0, 1'b0, "id_map_read");
    end
    drain();
    send(32'h0000_0040, 1'b0, 1'b0, "outside_access");
    send(32'hffff_fffc, 1'b0, 1'b0, "outside_access");
    send(32'h8000_0000, 1'b1, 1'b0, "outside_access");
    send(32'h0001_0008, 1'b1, 1'b0, "outside_access");
    drain();
    // DNA readout, poll the busy flag
    while (last_busy) begin
      send(32'h0000_000c, 1'b0, 1'b1, "dna_poll");
      drain();
    end
    assert (busy_polls > 0) else begin
      $display("DNA readout already finished at the first poll");
      proto_errs++;
    end
    dna_ready = 1'b1;
    send(32'h0000_0008, 1'b0, 1'b0, "dna_read");
    send(32'h0000_000c, 1'b0, 1'b0, "dna_read");
    drain();
    // Writes first, then every word read back
    for (k = 0; k < 16; k++) send({26'd0, 4'(k), 2'b00}, 1'b1, 1'b0, "write_then_read");
    for (k = 0; k < 16; k++) send({26'd0, 4'(k), 2'b00}, 1'b0, 1'b0, "write_then_read");
    drain();
    // One request per cycle, mixed regions
    for (k = 0; k < N_RANDOM; k++) begin
      sel = $urandom_range(0, 9);
      r   = $urandom;
      idx = 3'($urandom_range(0, 7));
      if (sel < 6) r = {26'd0, MAP_OFS[idx]};
      else if (sel < 8) r = {26'd0, r[5:2], 2'b00};
      else r[6] = 1'b1;
      send(r, ($urandom_range(0, 3) == 0), 1'b0, "random_traffic");
    end
    drain();
    assert_errs = u_sys_id_top.u_sys_id_assert.ack_fails
                  + u_sys_id_top.u_sys_id_assert.rst_fails
                  + u_sys_id_top.u_sys_id_assert.err_fails;
    $display("Error counts: data %0d, protocol %0d, assertion %0d",
             data_errs, proto_errs, assert_errs);
    if (data_errs + proto_errs + assert_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Run limit
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge bus);
    $display("Timeout: test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule
